// File: rtl/aluPkg.sv
/*
 ALU definitions shared by the datapath and the testbench.
 Operands arrive as sign-extended 16-bit words, so the ALU always runs at 32 bits.
 Carry and overflow carry meaning only for ADD and SUB.
*/
`default_nettype none

package aluPkg;

	localparam int dataWidth = 32; // ALU operand and result width
	localparam int opWidth = 3; // Width of the op field in an instruction
	localparam int flagWidth = 4; // Size of the flags word

	// Operation codes, taken straight from the low bits of an instruction
	localparam logic [opWidth-1:0] opNoop = 3'd0; // Passes A through
	localparam logic [opWidth-1:0] opAdd = 3'd1;
	localparam logic [opWidth-1:0] opSub = 3'd2; // A + ~B + 1
	localparam logic [opWidth-1:0] opAnd = 3'd3;
	localparam logic [opWidth-1:0] opOr = 3'd4;
	localparam logic [opWidth-1:0] opXor = 3'd5;
	localparam logic [opWidth-1:0] opSlt = 3'd6; // Signed compare, result is 0 or 1
	localparam logic [opWidth-1:0] opSll = 3'd7; // Shift by low 5 bits of B

	// Bit positions inside the flags word
	localparam int flagZero = 0;
	localparam int flagNeg = 1; // Copy of result bit 31
	localparam int flagCarry = 2; // Carry out of bit 31, ADD and SUB only
	localparam int flagOverflow = 3; // Signed overflow, ADD and SUB only

endpackage

`default_nettype wire

// File: rtl/memPkg.sv
/*
 Memory map and register file sizes of the exercise engine.
 Instructions sit at 0..15, operands at 16..47 and results go to 48..63.
 The map is fixed by the 16-bit instruction format and has no parameters.
*/
`default_nettype none

package memPkg;

	localparam int wordWidth = 16; // Memory and register word width
	localparam int memDepth = 64;
	localparam int memAddrWidth = 6;
	localparam int regCount = 32;
	localparam int regAddrWidth = 5;

	// Program memory regions
	localparam int instrBase = 0;
	localparam int instrCount = 16; // One result register per instruction
	localparam int operandBase = 16;
	localparam int operandCount = 32; // Fills the whole register file
	localparam int resultBase = 48; // Registers 0..15 land here after the run

	// Instruction layout, msb first
	typedef struct packed {
		logic [2:0] spare; // Ignored by the decoder
		logic [regAddrWidth-1:0] rdB; // Register feeding bus B
		logic [regAddrWidth-1:0] rdA; // Register feeding bus A
		logic [2:0] op; // Same coding as the ALU op codes
	} instrFields_s;

	// One memory word, read either as an instruction or as plain data
	typedef union packed {
		instrFields_s instr;
		logic [wordWidth-1:0] data;
	} memWord_u;

endpackage

`default_nettype wire

// File: rtl/alu.sv
/*
 Purely combinational 32-bit ALU.
 SLT compares signed and SLL uses only the low 5 bits of B.
 Carry and overflow read 0 for every operation except ADD and SUB.
*/
`timescale 1ns/100ps
`default_nettype none

module alu import aluPkg::*; (
	input wire [opWidth-1:0] aluOp,
	input wire [dataWidth-1:0] busA,
	input wire [dataWidth-1:0] busB,
	output logic [dataWidth-1:0] result,
	output logic [flagWidth-1:0] flags
);

	logic [dataWidth-1:0] operandB; // B, inverted for SUB
	logic [dataWidth:0] sum; // Top bit is the carry out
	logic isArith; // ADD or SUB, the only ops with carry and overflow

	always_comb begin
		operandB = (aluOp == opSub) ? ~busB : busB;
		// The +1 of two's complement rides in as the carry in
		sum = {1'b0, busA} + {1'b0, operandB} + {{dataWidth{1'b0}}, aluOp == opSub};

		case (aluOp)
			opNoop: result = busA;
			opAdd: result = sum[dataWidth-1:0];
			opSub: result = sum[dataWidth-1:0];
			opAnd: result = busA & busB;
			opOr: result = busA | busB;
			opXor: result = busA ^ busB;
			opSlt: result = {{(dataWidth-1){1'b0}}, $signed(busA) < $signed(busB)};
			opSll: result = busA << busB[$clog2(dataWidth)-1:0];
		endcase

		isArith = (aluOp == opAdd) || (aluOp == opSub);

		flags[flagZero] = (result == '0);
		flags[flagNeg] = result[dataWidth-1]; // Sign of the result
		flags[flagCarry] = isArith & sum[dataWidth];
		// Same-sign inputs giving a result of the other sign
		flags[flagOverflow] = isArith
			& (busA[dataWidth-1] == operandB[dataWidth-1])
			& (result[dataWidth-1] != busA[dataWidth-1]);
	end

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
/*
 32 x 16 register file, two combinational read ports, one write port.
 A write lands at the clock edge, so a same-cycle read sees the old word.
 Reset clears every register.
*/
`timescale 1ns/100ps
`default_nettype none

module registerFile import memPkg::*; (
	input wire clk,
	input wire reset,
	input wire wrEn,
	input wire [regAddrWidth-1:0] wrAddr,
	input wire [wordWidth-1:0] wrData,
	input wire [regAddrWidth-1:0] rdAddrA,
	input wire [regAddrWidth-1:0] rdAddrB,
	output logic [wordWidth-1:0] rdDataA,
	output logic [wordWidth-1:0] rdDataB
);

	logic [wordWidth-1:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData; // Load operand or ALU result
		end
	end

	// Read ports are plain muxes off the array
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

// File: rtl/programMemory.sv
/*
 64 x 16 program memory with registered reads.
 Writes come from the host while idle and from the sequencer while busy.
 The host read port works at any time and returns data one cycle after the address.
*/
`timescale 1ns/100ps
`default_nettype none

module programMemory import memPkg::*; (
	input wire clk,
	input wire busy,
	input wire hostWrEn,
	input wire [memAddrWidth-1:0] hostAddr,
	input wire [wordWidth-1:0] hostWrData,
	input wire [memAddrWidth-1:0] hostRdAddr,
	output logic [wordWidth-1:0] hostRdData,
	input wire [memAddrWidth-1:0] seqAddr,
	input wire seqWrEn,
	input wire [wordWidth-1:0] seqWrData,
	output logic [wordWidth-1:0] seqRdData
);

	logic [wordWidth-1:0] mem [memDepth];

	// Single write port, owner picked by busy
	always_ff @(posedge clk) begin
		if (busy) begin
			if (seqWrEn) begin
				mem[seqAddr] <= seqWrData; // Writeback of results
			end
		end else if (hostWrEn) begin
			mem[hostAddr] <= hostWrData; // Host image load
		end
	end

	// Sequencer read, used for operand load and instruction fetch
	always_ff @(posedge clk) begin
		seqRdData <= mem[seqAddr];
	end

	always_ff @(posedge clk) begin
		hostRdData <= mem[hostRdAddr]; // Independent of busy
	end

endmodule

`default_nettype wire

// File: rtl/sequencer.sv
/*
 Run sequencer for the load, execute and writeback phases.
 Load and execute steps take two cycles each and writeback steps take one.
 A start pulse is only taken while idle and there is no back-pressure.
 done pulses for one cycle, in the same cycle that busy falls.
*/
`timescale 1ns/100ps
`default_nettype none

module sequencer import aluPkg::*, memPkg::*; (
	input wire clk,
	input wire reset,
	input wire start,
	output logic busy,
	output logic done,
	output logic [memAddrWidth-1:0] seqAddr,
	output logic seqWrEn,
	output logic [wordWidth-1:0] seqWrData,
	input wire [wordWidth-1:0] seqRdData,
	output logic [regAddrWidth-1:0] rdAddrA,
	output logic [regAddrWidth-1:0] rdAddrB,
	input wire [wordWidth-1:0] rdDataA,
	input wire [wordWidth-1:0] rdDataB,
	output logic wrEn,
	output logic [regAddrWidth-1:0] wrAddr,
	output logic [wordWidth-1:0] wrData,
	output logic [opWidth-1:0] aluOp,
	output logic [dataWidth-1:0] busA,
	output logic [dataWidth-1:0] busB,
	input wire [dataWidth-1:0] aluResult,
	input wire [flagWidth-1:0] aluFlags,
	output logic resultValid,
	output logic [$clog2(instrCount)-1:0] resultIndex,
	output logic [dataWidth-1:0] result,
	output logic [flagWidth-1:0] flags
);

	// One-hot phase flags, all low when idle
	logic loading;
	logic executing;
	logic writingBack;
	logic second; // Second cycle of a load or execute step
	logic [regAddrWidth-1:0] count; // Word counter shared by all phases
	memWord_u fetched; // Memory read data seen as an instruction

	assign fetched.data = seqRdData;

	assign busy = loading | executing | writingBack;

	// Memory address for the current phase
	always_comb begin
		if (loading) begin
			seqAddr = memAddrWidth'(operandBase + count);
		end else if (executing) begin
			seqAddr = memAddrWidth'(instrBase + count);
		end else begin
			seqAddr = memAddrWidth'(resultBase + count); // Writeback, harmless when idle
		end
	end

	// Writeback copies register count straight to memory
	assign seqWrEn = writingBack;
	assign seqWrData = rdDataA;

	// Port A doubles as the writeback read port
	assign rdAddrA = writingBack ? count : fetched.instr.rdA;
	assign rdAddrB = fetched.instr.rdB;

	// Register write in the second cycle of load and execute
	assign wrEn = (loading | executing) & second;
	assign wrAddr = count; // Operand slot, or instruction index
	assign wrData = loading ? seqRdData : aluResult[wordWidth-1:0];

	assign aluOp = fetched.instr.op;
	// Sign-extend both register words onto the ALU buses
	assign busA = {{(dataWidth-wordWidth){rdDataA[wordWidth-1]}}, rdDataA};
	assign busB = {{(dataWidth-wordWidth){rdDataB[wordWidth-1]}}, rdDataB};

	always_ff @(posedge clk) begin
		if (reset) begin
			loading <= 1'b0;
			executing <= 1'b0;
			writingBack <= 1'b0;
			second <= 1'b0;
			count <= '0;
			done <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			done <= 1'b0; // Pulses only
			resultValid <= 1'b0;
			if (loading) begin
				second <= ~second; // Address cycle, then write cycle
				if (second) begin
					if (count == regAddrWidth'(operandCount - 1)) begin
						loading <= 1'b0;
						executing <= 1'b1;
						count <= '0;
					end else begin
						count <= count + 1'b1;
					end
				end
			end else if (executing) begin
				second <= ~second; // Fetch cycle, then compute and write
				resultValid <= second; // Strobe for the step just finished
				if (second) begin
					if (count == regAddrWidth'(instrCount - 1)) begin
						executing <= 1'b0;
						writingBack <= 1'b1;
						count <= '0;
					end else begin
						count <= count + 1'b1;
					end
				end
			end else if (writingBack) begin
				if (count == regAddrWidth'(instrCount - 1)) begin
					writingBack <= 1'b0; // busy drops with done
					done <= 1'b1;
					count <= '0;
				end else begin
					count <= count + 1'b1;
				end
			end else if (start) begin
				loading <= 1'b1; // Idle, take the start
				second <= 1'b0;
				count <= '0;
			end
		end
	end

	// Strobe payload, captured with the register write
	always_ff @(posedge clk) begin
		if (executing && second) begin
			resultIndex <= count[$clog2(instrCount)-1:0];
			result <= aluResult; // Full 32 bits, not just the stored half
			flags <= aluFlags;
		end
	end

endmodule

`default_nettype wire

// File: rtl/aluMemTop.sv
/*
 Top level of the ALU and memory exercise engine.
 The host may only write memory while busy is low and must wait for done.
 Host reads return data one cycle after hostRdAddr, busy or not.
*/
`timescale 1ns/100ps
`default_nettype none

module aluMemTop import aluPkg::*, memPkg::*; (
	input wire clk,
	input wire reset,
	input wire start,
	input wire hostWrEn,
	input wire [memAddrWidth-1:0] hostAddr,
	input wire [wordWidth-1:0] hostWrData,
	input wire [memAddrWidth-1:0] hostRdAddr,
	output logic [wordWidth-1:0] hostRdData,
	output logic busy,
	output logic done,
	output logic resultValid,
	output logic [$clog2(instrCount)-1:0] resultIndex,
	output logic [dataWidth-1:0] result,
	output logic [flagWidth-1:0] flags
);

	// Sequencer to memory
	logic [memAddrWidth-1:0] seqAddr;
	logic seqWrEn;
	logic [wordWidth-1:0] seqWrData;
	logic [wordWidth-1:0] seqRdData;

	// Sequencer to register file
	logic [regAddrWidth-1:0] rdAddrA;
	logic [regAddrWidth-1:0] rdAddrB;
	logic [wordWidth-1:0] rdDataA;
	logic [wordWidth-1:0] rdDataB;
	logic wrEn;
	logic [regAddrWidth-1:0] wrAddr;
	logic [wordWidth-1:0] wrData;

	// Sequencer to ALU
	logic [opWidth-1:0] aluOp;
	logic [dataWidth-1:0] busA;
	logic [dataWidth-1:0] busB;
	logic [dataWidth-1:0] aluResult;
	logic [flagWidth-1:0] aluFlags;

	programMemory memory (
		.clk(clk), .busy(busy),
		.hostWrEn(hostWrEn), .hostAddr(hostAddr), .hostWrData(hostWrData),
		.hostRdAddr(hostRdAddr), .hostRdData(hostRdData),
		.seqAddr(seqAddr), .seqWrEn(seqWrEn), .seqWrData(seqWrData),
		.seqRdData(seqRdData)
	);

	sequencer control (
		.clk(clk), .reset(reset), .start(start), .busy(busy), .done(done),
		.seqAddr(seqAddr), .seqWrEn(seqWrEn), .seqWrData(seqWrData), .seqRdData(seqRdData),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.aluOp(aluOp), .busA(busA), .busB(busB), .aluResult(aluResult), .aluFlags(aluFlags),
		.resultValid(resultValid), .resultIndex(resultIndex), .result(result), .flags(flags)
	);

	registerFile regs (
		.clk(clk), .reset(reset),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	alu datapath (
		.aluOp(aluOp), .busA(busA), .busB(busB), .result(aluResult), .flags(aluFlags)
	);

endmodule

`default_nettype wire

// File: test/aluMemTb.sv
/*
 Self-checking testbench for the ALU and memory engine.
 Two directed images come from test/aluMemTestdata.txt, a third is random.
 Flags, full results and the writeback region are checked against a behavioral model.
*/
`timescale 1ns/100ps
`default_nettype none

module aluMemTb import aluPkg::*, memPkg::*; ();

	localparam int clkPeriod = 40;
	localparam int resetCycles = 3;
	localparam int directedCount = 2;
	localparam int wordsPerTest = 64; // 48 image words, then 16 expected results
	localparam int imageWords = operandBase + operandCount;
	localparam int runCycles = 114; // Start to done
	localparam int testCount = 4; // Idle access check, two directed, one random
	// Image load, run and full readback, with a factor of two in hand
	localparam int cyclesPerTest = 2 * (imageWords + runCycles + memDepth);
	localparam int watchdogCycles = resetCycles + testCount * cyclesPerTest;

	logic clk;
	logic reset;
	logic start;
	logic hostWrEn;
	logic [memAddrWidth-1:0] hostAddr;
	logic [wordWidth-1:0] hostWrData;
	logic [memAddrWidth-1:0] hostRdAddr;
	logic [wordWidth-1:0] hostRdData;
	logic busy;
	logic done;
	logic resultValid;
	logic [$clog2(instrCount)-1:0] resultIndex;
	logic [dataWidth-1:0] result;
	logic [flagWidth-1:0] flags;

	logic [wordWidth-1:0] testData [directedCount*wordsPerTest];
	logic [wordWidth-1:0] image [imageWords]; // Image under test
	logic [wordWidth-1:0] expWord [instrCount]; // Expected low halves from the file
	logic [dataWidth-1:0] modelResult [instrCount];
	logic [flagWidth-1:0] modelFlags [instrCount];
	logic [wordWidth-1:0] modelRegs [regCount];

	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int strobeCount = 0;
	int doneCount = 0;
	int seedValue;
	logic checkingRun = 1'b0; // Strobes are expected only inside a run
	logic fileCheck = 1'b0; // Compare against file results too

	aluMemTop DUT (
		.clk(clk), .reset(reset), .start(start),
		.hostWrEn(hostWrEn), .hostAddr(hostAddr), .hostWrData(hostWrData),
		.hostRdAddr(hostRdAddr), .hostRdData(hostRdData),
		.busy(busy), .done(done), .resultValid(resultValid),
		.resultIndex(resultIndex), .result(result), .flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod/2) clk = ~clk;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout: no result after %0d cycles, the engine never finished",
			watchdogCycles);
		$display("sim failed");
		$finish;
	end

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error: %s is %h, expected %h", name, got, exp);
		errorCount++;
	endtask

	task automatic reportProblem(input string text);
		$display("Problem: %s", text);
		errorCount++;
	endtask

	// ALU behavior as the operation and flag rules describe it
	task automatic aluModel(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
		output logic [31:0] res, output logic [3:0] flg);
		logic [32:0] wide;
		wide = '0;
		flg = '0;
		case (op)
			opNoop: res = a;
			opAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[31:0];
				flg[flagCarry] = wide[32];
				flg[flagOverflow] = (a[31] == b[31]) && (res[31] != a[31]);
			end
			opSub: begin
				wide = {1'b0, a} + {1'b0, ~b} + 33'd1; // A + ~B + 1
				res = wide[31:0];
				flg[flagCarry] = wide[32];
				flg[flagOverflow] = (a[31] != b[31]) && (res[31] != a[31]);
			end
			opAnd: res = a & b;
			opOr: res = a | b;
			opXor: res = a ^ b;
			opSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: res = a << b[4:0]; // SLL
		endcase
		flg[flagZero] = (res == 32'd0);
		flg[flagNeg] = res[31];
	endtask

	// Whole run on the image, register i overwritten after instruction i
	task automatic modelRun();
		memWord_u word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [3:0] flg;
		for (int r = 0; r < regCount; r++) modelRegs[r] = image[operandBase + r];
		for (int i = 0; i < instrCount; i++) begin
			word.data = image[instrBase + i];
			a = {{16{modelRegs[word.instr.rdA][15]}}, modelRegs[word.instr.rdA]};
			b = {{16{modelRegs[word.instr.rdB][15]}}, modelRegs[word.instr.rdB]};
			aluModel(word.instr.op, a, b, res, flg);
			modelResult[i] = res;
			modelFlags[i] = flg;
			modelRegs[i] = res[15:0];
		end
	endtask

	task automatic hostWrite(input int addr, input logic [15:0] data);
		hostWrEn = 1'b1;
		hostAddr = addr[memAddrWidth-1:0];
		hostWrData = data;
		@(negedge clk);
		hostWrEn = 1'b0;
	endtask

	task automatic hostRead(input int addr, output logic [15:0] data);
		hostRdAddr = addr[memAddrWidth-1:0];
		@(negedge clk); // Registered read
		data = hostRdData;
	endtask

	task automatic loadImage();
		for (int w = 0; w < imageWords; w++) hostWrite(w, image[w]);
	endtask

	task automatic fillRandomImage();
		logic [31:0] randWord;
		for (int w = 0; w < imageWords; w++) begin
			randWord = $urandom;
			image[w] = randWord[15:0]; // Spare instruction bits random too
		end
	endtask

	task automatic finishTest(input int num, input string name, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("Test %0d (%s): passed", num, name);
		end else begin
			failCount++;
			$display("Test %0d (%s): failed with %0d errors", num, name,
				errorCount - errorsBefore);
		end
	endtask

	// Idle state after reset and a plain host write and read
	task automatic checkIdleAccess();
		int errorsBefore;
		logic [15:0] word;
		errorsBefore = errorCount;
		if (busy !== 1'b0) reportMismatch("busy", busy, 0);
		if (done !== 1'b0) reportMismatch("done", done, 0);
		if (resultValid !== 1'b0) reportMismatch("resultValid", resultValid, 0);
		hostWrite(63, 16'h3C5A);
		hostRead(63, word);
		if (word !== 16'h3C5A) reportMismatch("hostRdData", word, 16'h3C5A);
		finishTest(0, "reset and host access", errorsBefore);
	endtask

	task automatic runTest(input int num, input string name, input logic useFile);
		int errorsBefore;
		int doneBefore;
		logic [15:0] word;
		errorsBefore = errorCount;
		loadImage();
		modelRun();
		strobeCount = 0;
		fileCheck = useFile;
		doneBefore = doneCount;
		checkingRun = 1'b1;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (busy !== 1'b1) reportProblem("busy did not rise after start");
		repeat (4) @(negedge clk);
		// Start and host write while busy, both must be ignored
		start = 1'b1;
		hostWrEn = 1'b1;
		hostAddr = 3;
		hostWrData = ~image[3];
		@(negedge clk);
		start = 1'b0;
		hostWrEn = 1'b0;
		while (done !== 1'b1) @(negedge clk); // Watchdog bounds this wait
		if (busy !== 1'b0) reportMismatch("busy", busy, 0);
		repeat (4) @(negedge clk);
		checkingRun = 1'b0;
		if (busy !== 1'b0) reportProblem("busy rose again after done, a busy-time start was taken");
		if (doneCount != doneBefore + 1)
			reportProblem($sformatf("expected one done pulse, saw %0d", doneCount - doneBefore));
		if (strobeCount != instrCount)
			reportProblem($sformatf("saw %0d result strobes instead of 16", strobeCount));
		for (int a = 0; a < memDepth; a++) begin
			hostRead(a, word);
			if (a < resultBase) begin
				if (word !== image[a])
					reportMismatch($sformatf("memory[%0d]", a), word, image[a]);
			end else begin
				if (word !== modelRegs[a - resultBase])
					reportMismatch($sformatf("memory[%0d]", a), word, modelRegs[a - resultBase]);
			end
		end
		finishTest(num, name, errorsBefore);
	endtask

	// Strobe checker, outputs are settled at the falling edge
	always @(negedge clk) begin
		if (done === 1'b1) doneCount++;
		if (resultValid === 1'b1) begin
			if (!checkingRun) begin
				reportProblem("resultValid pulsed outside a run");
			end else if (strobeCount >= instrCount) begin
				reportProblem("more than 16 result strobes in one run");
			end else begin
				if (resultIndex !== strobeCount[3:0])
					reportMismatch("resultIndex", resultIndex, strobeCount);
				if (result !== modelResult[strobeCount])
					reportMismatch("result", result, modelResult[strobeCount]);
				if (flags !== modelFlags[strobeCount])
					reportMismatch("flags", flags, modelFlags[strobeCount]);
				if (fileCheck && result[15:0] !== expWord[strobeCount])
					reportMismatch("result[15:0]", result[15:0], expWord[strobeCount]);
				strobeCount++;
			end
		end
	end

	initial begin
		seedValue = $urandom(99941);
		reset = 1'b1;
		start = 1'b0;
		hostWrEn = 1'b0;
		hostAddr = '0;
		hostWrData = '0;
		hostRdAddr = '0;
		$readmemh("test/aluMemTestdata.txt", testData);
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;
		checkIdleAccess();
		for (int t = 0; t < directedCount; t++) begin
			for (int w = 0; w < imageWords; w++) image[w] = testData[t*wordsPerTest + w];
			for (int i = 0; i < instrCount; i++) begin
				expWord[i] = testData[t*wordsPerTest + imageWords + i];
			end
			if (t == 0) begin
				runTest(t + 1, "all operations", 1'b1);
			end else begin
				runTest(t + 1, "carry and overflow edges", 1'b1);
			end
		end
		fillRandomImage();
		runTest(3, "random image", 1'b0);
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/aluMemTestdata.txt
// Two directed tests of 64 hex words each
// Per test: 16 instructions, 32 operands for r0..r31, 16 expected low result words
// Test 1, all eight operations, instructions at 0..15
0080 1181 1282 149B 149C 18FD 1196 178F
18A9 108A 1286 1DE7 0209 0D72 092D 00B0
// Test 1 operands
1000 1001 1002 1003 1004 1005 1006 1007
1008 1009 100A 100B 100C 100D 100E 100F
0005 0003 FFFE 00F0 0F0F 8000 7FFF 0004
FFFF 1234 00FF 0010 FF00 0001 0002 A5A5
// Test 1 expected registers 0..15
0005 0008 0007 0000 0FFF 5A5A 0001 0030
7FFF FFFE 0000 FE00 000F 0001 A5A4 7FFF
// Test 2, carry and overflow edges, instructions
1181 1192 1199 14A2 11A2 1291 1081 168F
178F 18AF 1096 1286 149E 0101 129B 1035
// Test 2 operands
2000 2001 2002 2003 2004 2005 2006 2007
2008 2009 200A 200B 200C 200D 200E 200F
7FFF 0001 8000 FFFF 0000 4000 000F 001F
0010 0123 4567 89AB CDEF 0F0F F0F0 5555
// Test 2 expected registers 0..15
8000 7FFF 0000 0000 FFFF 0000 FFFE 8000
0000 0000 0001 0000 0001 FFFF 8000 8001

// File: filelist.f
rtl/aluPkg.sv
rtl/memPkg.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/programMemory.sv
rtl/sequencer.sv
rtl/aluMemTop.sv
test/aluMemTb.sv
